// File: Makefile
# Verilator build and run of the serial command master testbench.
TOP := uart_cmd_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f build.f
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: build.f
logic/uart_cfg_pkg.sv
logic/uart_cmd_pkg.sv
logic/uart_byte_if.sv
logic/uart_byte_tx.sv
logic/uart_byte_rx.sv
logic/uart_cmd_ctrl.sv
logic/uart_cmd_top.sv
sim/uart_peer_model.sv
sim/uart_cmd_tb.sv

// File: logic/uart_byte_if.sv
`timescale 1ns/100ps

// one byte out through the framer.
interface byte_tx_if;
  logic                              start;
  logic [uart_cfg_pkg::data_bits-1:0] data;
  logic                              busy;
  logic                              done;

  modport ctrl (
    output start,
    output data,
    input  busy,
    input  done
  );

  modport framer (
    input  start,
    input  data,
    output busy,
    output done
  );
endinterface

// one armed byte back from the deframer.
interface byte_rx_if;
  logic                              arm;
  logic [uart_cfg_pkg::data_bits-1:0] data;
  logic                              valid;
  logic                              err;
  logic                              timeout;

  modport ctrl (
    output arm,
    input  data,
    input  valid,
    input  err,
    input  timeout
  );

  modport deframer (
    input  arm,
    output data,
    output valid,
    output err,
    output timeout
  );
endinterface

// File: logic/uart_byte_rx.sv
`timescale 1ns/100ps

module uart_byte_rx (
  input  logic        clk,
  input  logic        rst_n,
  byte_rx_if.deframer bus,
  input  logic        rx
);

  logic                                    rx_meta;
  logic                                    rx_sync;
  logic                                    rx_prev;
  logic                                    fall;
  logic                                    active;
  logic                                    mid;
  logic [uart_cfg_pkg::bit_cnt_w-1:0]     baud_cnt;
  logic [uart_cfg_pkg::bit_idx_w-1:0]     bit_idx;
  logic [uart_cfg_pkg::timeout_cnt_w-1:0] timeout_cnt;
  logic [uart_cfg_pkg::data_bits-1:0]     shift_q;
  logic                                    par_q;
  logic                                    valid_q;
  logic                                    err_q;
  logic                                    timeout_q;

  assign fall = rx_prev && !rx_sync;
  assign mid = active && (baud_cnt == uart_cfg_pkg::sample_point);

  assign bus.data = shift_q;
  assign bus.valid = valid_q;
  assign bus.err = err_q;
  assign bus.timeout = timeout_q;

  // two-flop synchronizer plus an edge flop.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active <= 1'b0;
      baud_cnt <= '0;
      bit_idx <= '0;
      timeout_cnt <= '0;
      valid_q <= 1'b0;
      err_q <= 1'b0;
      timeout_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      timeout_q <= 1'b0;
      if (!active)
      begin
        baud_cnt <= '0;
        bit_idx <= '0;
        if (!bus.arm)
          timeout_cnt <= '0;
        else if (fall)
        begin
          active <= 1'b1;
          timeout_cnt <= '0;
        end
        else if (timeout_cnt == uart_cfg_pkg::timeout_last)
        begin
          timeout_q <= 1'b1;
          timeout_cnt <= '0;
        end
        else
          timeout_cnt <= timeout_cnt + 1'b1;
      end
      else
      begin
        if (baud_cnt == uart_cfg_pkg::bit_last)
        begin
          baud_cnt <= '0;
          bit_idx <= bit_idx + 1'b1;
        end
        else
          baud_cnt <= baud_cnt + 1'b1;
        // a start bit gone high again by mid-bit was a glitch.
        if (mid && (bit_idx == '0) && rx_sync)
          active <= 1'b0;
        else if (mid && (bit_idx == uart_cfg_pkg::stop_idx))
        begin
          active <= 1'b0;
          valid_q <= 1'b1;
          err_q <= !(^{par_q, shift_q}) || !rx_sync;
        end
      end
    end
  end

  // lsb arrives first.
  always_ff @(posedge clk)
  begin
    if (mid && (bit_idx != '0) && (bit_idx < uart_cfg_pkg::parity_idx))
      shift_q <= {rx_sync, shift_q[uart_cfg_pkg::data_bits-1:1]};
    else if (mid && (bit_idx == uart_cfg_pkg::parity_idx))
      par_q <= rx_sync;
  end

  result_while_armed: assert property (@(posedge clk) disable iff (!rst_n)
    (bus.valid || bus.timeout) |-> bus.arm)
    else $error("reply result while the deframer is not armed");

endmodule

// File: logic/uart_byte_tx.sv
`timescale 1ns/100ps

module uart_byte_tx (
  input  logic      clk,
  input  logic      rst_n,
  byte_tx_if.framer bus,
  output logic      tx
);

  logic                                busy_q;
  logic [uart_cfg_pkg::bit_cnt_w-1:0] baud_cnt;
  logic [uart_cfg_pkg::bit_idx_w-1:0] bit_idx;
  logic [uart_cfg_pkg::data_bits-1:0] shift_q;
  logic                                parity_q;
  logic                                bit_end;

  assign bit_end = busy_q && (baud_cnt == uart_cfg_pkg::bit_last);
  assign bus.busy = busy_q;
  // last cycle of the stop bit.
  assign bus.done = bit_end && (bit_idx == uart_cfg_pkg::stop_idx);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q <= 1'b0;
      baud_cnt <= '0;
      bit_idx <= '0;
      tx <= 1'b1;
    end
    else if (!busy_q)
    begin
      if (bus.start)
      begin
        busy_q <= 1'b1;
        baud_cnt <= '0;
        bit_idx <= '0;
        tx <= 1'b0;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      bit_idx <= bit_idx + 1'b1;
      if (bit_idx == uart_cfg_pkg::stop_idx)
        busy_q <= 1'b0;
      else if (bit_idx == uart_cfg_pkg::parity_idx)
        tx <= 1'b1;
      else if (bit_idx == uart_cfg_pkg::data_last_idx)
        tx <= parity_q;
      else
        tx <= shift_q[0];
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

  // odd parity, so the frame carries an odd count of ones.
  always_ff @(posedge clk)
  begin
    if (!busy_q && bus.start)
    begin
      shift_q <= bus.data;
      parity_q <= ~^bus.data;
    end
    else if (bit_end && (bit_idx < uart_cfg_pkg::data_last_idx))
      shift_q <= shift_q >> 1;
  end

  start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    bus.start |-> !busy_q)
    else $error("byte start while the framer is busy");

endmodule

// File: logic/uart_cfg_pkg.sv
package uart_cfg_pkg;

  // line timing, kept short for simulation.
  localparam int bit_cycles = 16;
  localparam int data_bits = 8;
  // start, data, parity and stop.
  localparam int frame_bits = data_bits + 3;
  localparam int gap_cycles = 100;
  localparam int reply_timeout_cycles = 40 * bit_cycles;

  localparam int bit_cnt_w = $clog2(bit_cycles);
  localparam int bit_idx_w = $clog2(frame_bits);
  localparam int gap_cnt_w = $clog2(gap_cycles);
  localparam int timeout_cnt_w = $clog2(reply_timeout_cycles);

  // compare points, sized to the counters.
  localparam logic [bit_cnt_w-1:0] sample_point = bit_cnt_w'(bit_cycles / 2);
  localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(bit_cycles - 1);
  localparam logic [bit_idx_w-1:0] data_last_idx = bit_idx_w'(data_bits);
  localparam logic [bit_idx_w-1:0] parity_idx = bit_idx_w'(data_bits + 1);
  localparam logic [bit_idx_w-1:0] stop_idx = bit_idx_w'(frame_bits - 1);
  localparam logic [gap_cnt_w-1:0] gap_last = gap_cnt_w'(gap_cycles - 1);
  localparam logic [timeout_cnt_w-1:0] timeout_last =
    timeout_cnt_w'(reply_timeout_cycles - 1);

endpackage

// File: logic/uart_cmd_ctrl.sv
`timescale 1ns/100ps

module uart_cmd_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0]  cmd,
  input  logic                                cmd_vld,
  output logic                                cmd_rdy,
  byte_tx_if.ctrl                             txb,
  byte_rx_if.ctrl                             rxb,
  output logic [uart_cfg_pkg::data_bits-1:0]  read_data,
  output logic                                read_rdy,
  output logic                                read_err,
  output logic                                read_timeout
);

  uart_cmd_pkg::ctrl_state_e               state;
  uart_cmd_pkg::ctrl_state_e               state_nxt;
  uart_cmd_pkg::cmd_kind_e                 kind;
  logic [uart_cmd_pkg::cmd_width-1:0]      cmd_q;
  logic [uart_cfg_pkg::gap_cnt_w-1:0]      gap_cnt;
  logic                                    accept;
  logic                                    gap_done;
  logic                                    reply_in;

  assign accept = cmd_rdy && cmd_vld;
  assign gap_done = (state == uart_cmd_pkg::st_gap) && (gap_cnt == uart_cfg_pkg::gap_last);
  assign reply_in = (state == uart_cmd_pkg::st_wait_reply) && rxb.valid;
  assign kind = uart_cmd_pkg::cmd_kind_e'(cmd_q[uart_cmd_pkg::rw_bit]);

  // high byte straight from the host, so the frame starts next cycle.
  assign txb.start = accept || gap_done;
  assign txb.data = accept ? cmd[uart_cmd_pkg::cmd_width-1 -: uart_cfg_pkg::data_bits]
                           : cmd_q[uart_cfg_pkg::data_bits-1:0];

  always_comb
  begin
    state_nxt = state;
    case (state)
      uart_cmd_pkg::st_idle:
        if (accept)
          state_nxt = uart_cmd_pkg::st_send_hi;
      uart_cmd_pkg::st_send_hi:
        if (txb.done)
          state_nxt = uart_cmd_pkg::st_gap;
      uart_cmd_pkg::st_gap:
        if (gap_done)
          state_nxt = uart_cmd_pkg::st_send_lo;
      uart_cmd_pkg::st_send_lo:
        if (txb.done)
          state_nxt = (kind == uart_cmd_pkg::cmd_write) ? uart_cmd_pkg::st_idle
                                                        : uart_cmd_pkg::st_wait_reply;
      uart_cmd_pkg::st_wait_reply:
        if (rxb.valid || rxb.timeout)
          state_nxt = uart_cmd_pkg::st_recv_reply;
      default:
        state_nxt = uart_cmd_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= uart_cmd_pkg::st_idle;
      cmd_rdy <= 1'b1;
      rxb.arm <= 1'b0;
      gap_cnt <= '0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      read_timeout <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      cmd_rdy <= (state_nxt == uart_cmd_pkg::st_idle);
      // armed the cycle after the second done, dropped after the result.
      rxb.arm <= (state_nxt == uart_cmd_pkg::st_wait_reply);
      if (state == uart_cmd_pkg::st_gap)
        gap_cnt <= gap_cnt + 1'b1;
      else
        gap_cnt <= '0;
      read_rdy <= reply_in;
      read_timeout <= (state == uart_cmd_pkg::st_wait_reply) && rxb.timeout;
      if (reply_in)
        read_err <= rxb.err;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
    if (reply_in)
      read_data <= rxb.data;
  end

  rdy_framer_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> !txb.busy)
    else $error("cmd_rdy high while the framer is busy");

endmodule

// File: logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int cmd_width = 16;
  // write flag, high byte goes out first.
  localparam int rw_bit = 15;

  typedef enum logic
  {
    cmd_read  = 1'b0,
    cmd_write = 1'b1
  } cmd_kind_e;

  typedef enum logic [2:0]
  {
    st_idle       = 3'd0,
    st_send_hi    = 3'd1,
    st_gap        = 3'd2,
    st_send_lo    = 3'd3,
    st_wait_reply = 3'd4,
    st_recv_reply = 3'd5
  } ctrl_state_e;

endpackage

// File: logic/uart_cmd_top.sv
`timescale 1ns/100ps

module uart_cmd_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [uart_cmd_pkg::cmd_width-1:0]  cmd,
  input  logic                                cmd_vld,
  input  logic                                rx,
  output logic                                cmd_rdy,
  output logic                                tx,
  output logic [uart_cfg_pkg::data_bits-1:0]  read_data,
  output logic                                read_rdy,
  output logic                                read_err,
  output logic                                read_timeout
);

  byte_tx_if txb ();
  byte_rx_if rxb ();

  uart_cmd_ctrl ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .txb          (txb.ctrl),
    .rxb          (rxb.ctrl),
    .read_data    (read_data),
    .read_rdy     (read_rdy),
    .read_err     (read_err),
    .read_timeout (read_timeout)
  );

  uart_byte_tx tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (txb.framer),
    .tx    (tx)
  );

  uart_byte_rx rx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (rxb.deframer),
    .rx    (rx)
  );

endmodule

// File: sim/uart_cmd_tb.sv
`timescale 1ns/100ps

module uart_cmd_tb;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        tx;
  logic        rx;
  logic [7:0]  read_data;
  logic        read_rdy;
  logic        read_err;
  logic        read_timeout;
  logic        flip_parity;
  logic        silent;
  logic [7:0]  peer_hi;
  logic [7:0]  peer_lo;
  int          pair_cnt;
  int          bad_frames;
  int          gap_run;
  int          seed;
  int          errors = 0;
  int          passed = 0;
  int          rdy_cnt = 0;
  int          to_cnt = 0;
  logic [7:0]  last_data;
  logic        last_err;

  uart_cmd_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_vld      (cmd_vld),
    .rx           (rx),
    .cmd_rdy      (cmd_rdy),
    .tx           (tx),
    .read_data    (read_data),
    .read_rdy     (read_rdy),
    .read_err     (read_err),
    .read_timeout (read_timeout)
  );

  uart_peer_model peer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .rx          (rx),
    .flip_parity (flip_parity),
    .silent      (silent),
    .hi_byte     (peer_hi),
    .lo_byte     (peer_lo),
    .pair_cnt    (pair_cnt),
    .bad_frames  (bad_frames),
    .gap_run     (gap_run)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task note_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task end_test(input string name, input int mark);
    if (errors == mark)
    begin
      passed++;
      $display("%s: passed", name);
    end
    else
      $display("%s: failed with %0d errors", name, errors - mark);
  endtask

  // result pulses seen on the read outputs.
  always @(posedge clk)
  begin
    if (read_rdy)
    begin
      rdy_cnt <= rdy_cnt + 1;
      last_data <= read_data;
      last_err <= read_err;
    end
    if (read_timeout)
      to_cnt <= to_cnt + 1;
  end

  accept_drops_rdy: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else note_error("cmd_rdy still high after acceptance");

  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else note_error("tx low while the master is idle");

  rdy_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else note_error("read_rdy held for more than one cycle");

  timeout_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_timeout |=> !(read_timeout || read_rdy))
    else note_error("read_timeout held or followed by read_rdy");

  task automatic issue_cmd(input logic [15:0] c, output int cycles);
    int pairs0;
    pairs0 = pair_cnt;
    cmd <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    cycles = 0;
    @(posedge clk);
    while (!cmd_rdy)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (pair_cnt == pairs0 + 1)
      else note_error("peer did not decode a byte pair");
    assert (peer_hi == c[15:8] && peer_lo == c[7:0])
      else note_error($sformatf("peer got %h %h for command %h", peer_hi, peer_lo, c));
    assert (bad_frames == 0)
      else note_error("peer saw a bad parity or stop bit");
    // let the peer finish its reply before the next command.
    repeat (2 * uart_cfg_pkg::bit_cycles) @(posedge clk);
  endtask

  task automatic run_write(input logic [15:0] c);
    int cycles;
    int rdy0;
    int to0;
    rdy0 = rdy_cnt;
    to0 = to_cnt;
    issue_cmd(c, cycles);
    assert (cycles <= 2 * uart_cfg_pkg::frame_bits * uart_cfg_pkg::bit_cycles
                      + uart_cfg_pkg::gap_cycles + 8)
      else note_error($sformatf("write took %0d cycles", cycles));
    assert (rdy_cnt == rdy0 && to_cnt == to0)
      else note_error("read result pulse after a write");
  endtask

  task automatic run_read(input logic [15:0] c, input logic expect_err);
    int cycles;
    int rdy0;
    int to0;
    rdy0 = rdy_cnt;
    to0 = to_cnt;
    issue_cmd(c, cycles);
    assert (rdy_cnt == rdy0 + 1 && to_cnt == to0)
      else note_error("read did not give exactly one read_rdy pulse");
    assert (last_err == expect_err)
      else note_error($sformatf("read_err %b, expected %b", last_err, expect_err));
    if (!expect_err)
      assert (last_data == (c[7:0] ^ 8'h5A))
        else note_error($sformatf("read_data %h for command %h", last_data, c));
  endtask

  initial
  begin
    int         limit;
    int         cmd_len;
    int         reply_len;
    cmd_len = 2 * uart_cfg_pkg::frame_bits * uart_cfg_pkg::bit_cycles
              + uart_cfg_pkg::gap_cycles + 4 * uart_cfg_pkg::bit_cycles;
    reply_len = uart_cfg_pkg::frame_bits * uart_cfg_pkg::bit_cycles
                + uart_cfg_pkg::reply_timeout_cycles;
    limit = 2 * (20 + 11 * cmd_len + 6 * reply_len);
    repeat (limit) @(posedge clk);
    $display("watchdog: the run hung and did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    logic [15:0] c;
    int          mark;
    int          cycles;
    int          rdy0;
    int          to0;
    seed = 37;
    rst_n = 1'b0;
    cmd = '0;
    cmd_vld = 1'b0;
    flip_parity = 1'b0;
    silent = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    mark = errors;
    assert (tx === 1'b1 && cmd_rdy === 1'b1)
      else note_error("tx or cmd_rdy not high after reset");
    assert (read_rdy === 1'b0 && read_err === 1'b0 && read_timeout === 1'b0)
      else note_error("read outputs not low after reset");
    end_test("reset state", mark);

    mark = errors;
    repeat (4)
    begin
      c = 16'($random(seed));
      c[15] = 1'b1;
      run_write(c);
    end
    end_test("write framing", mark);

    mark = errors;
    c = 16'($random(seed));
    c[15] = 1'b1;
    run_write(c);
    // stop bit plus the idle gap.
    assert (gap_run >= uart_cfg_pkg::gap_cycles + uart_cfg_pkg::bit_cycles)
      else note_error($sformatf("tx high for only %0d cycles between bytes", gap_run));
    end_test("inter-byte gap", mark);

    mark = errors;
    repeat (4)
    begin
      c = 16'($random(seed));
      c[15] = 1'b0;
      run_read(c, 1'b0);
    end
    end_test("read reply", mark);

    mark = errors;
    flip_parity <= 1'b1;
    c = 16'($random(seed));
    c[15] = 1'b0;
    run_read(c, 1'b1);
    flip_parity <= 1'b0;
    end_test("corrupted reply", mark);

    mark = errors;
    silent <= 1'b1;
    c = 16'($random(seed));
    c[15] = 1'b0;
    rdy0 = rdy_cnt;
    to0 = to_cnt;
    issue_cmd(c, cycles);
    assert (to_cnt == to0 + 1 && rdy_cnt == rdy0)
      else note_error("silent peer did not give exactly one read_timeout pulse");
    assert (cmd_rdy === 1'b1)
      else note_error("cmd_rdy low after the timeout");
    silent <= 1'b0;
    end_test("silent peer", mark);

    $display("tests passed: %0d of 6, errors: %0d", passed, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: sim/uart_peer_model.sv
`timescale 1ns/100ps

// remote device on the serial line.
module uart_peer_model (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx,
  output logic       rx,
  input  logic       flip_parity,
  input  logic       silent,
  output logic [7:0] hi_byte,
  output logic [7:0] lo_byte,
  output int         pair_cnt,
  output int         bad_frames,
  output int         gap_run
);

  int high_run = 0;

  // length of the current run of high samples on tx.
  always @(posedge clk)
  begin
    if (tx === 1'b1)
      high_run <= high_run + 1;
    else
      high_run <= 0;
  end

  task automatic recv_byte(output logic [7:0] b, output logic bad, output int run);
    logic par;
    logic stop;
    do
      @(posedge clk);
    while (tx !== 1'b0);
    run = high_run;
    repeat (uart_cfg_pkg::bit_cycles / 2) @(posedge clk);
    bad = (tx !== 1'b0);
    for (int i = 0; i < uart_cfg_pkg::data_bits; i++)
    begin
      repeat (uart_cfg_pkg::bit_cycles) @(posedge clk);
      b[i] = tx;
    end
    repeat (uart_cfg_pkg::bit_cycles) @(posedge clk);
    par = tx;
    repeat (uart_cfg_pkg::bit_cycles) @(posedge clk);
    stop = tx;
    bad = bad || (^{par, b} !== 1'b1) || (stop !== 1'b1);
  endtask

  task automatic send_reply(input logic [7:0] b, input logic flip);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ flip, b, 1'b0};
    for (int i = 0; i < uart_cfg_pkg::frame_bits; i++)
    begin
      rx <= frame[i];
      repeat (uart_cfg_pkg::bit_cycles) @(posedge clk);
    end
  endtask

  initial
  begin
    logic [7:0] hi;
    logic [7:0] lo;
    logic       bad_hi;
    logic       bad_lo;
    int         run;
    rx = 1'b1;
    pair_cnt = 0;
    bad_frames = 0;
    gap_run = 0;
    wait (rst_n === 1'b1);
    forever
    begin
      recv_byte(hi, bad_hi, run);
      recv_byte(lo, bad_lo, run);
      hi_byte <= hi;
      lo_byte <= lo;
      gap_run <= run;
      if (bad_hi || bad_lo)
        bad_frames <= bad_frames + 1;
      pair_cnt <= pair_cnt + 1;
      // bit 7 of the high byte is the write flag.
      if (!hi[7] && !silent)
      begin
        repeat (2 * uart_cfg_pkg::bit_cycles) @(posedge clk);
        send_reply(lo ^ 8'h5A, flip_parity);
      end
    end
  end

endmodule
